//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int PC_W         = 32;
    localparam int NUM_WAYS     = 8;
    localparam int NUM_SETS     = 64;
    localparam int WAY_W        = 3;
    localparam int INDEX_W      = 6;
    localparam int OFFSET_W     = 3;
    localparam int TAG_W        = PC_W - INDEX_W - OFFSET_W;
    localparam int LINE_W       = 64;
    localparam int INSTR_W      = 32;
    localparam int PLRU_W       = NUM_WAYS - 1;
    localparam int UNCACHED_BIT = 31;  // Set means cached space

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [PC_W-1:0] raw;
        addr_fields_t    fields;
    } fetch_addr_t;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_MISALIGN,
        TRAP_FETCH_FAULT
    } trap_t;

    typedef struct packed {
        logic [PC_W-1:0] pc;
        logic            fence;  // fence.i, no response
    } fetch_req_t;

    typedef struct packed {
        logic [PC_W-1:0]    pc;
        logic [INSTR_W-1:0] instr;
        trap_t              trap;
    } fetch_resp_t;

    typedef logic [NUM_WAYS-1:0] way_vec_t;

endpackage

`default_nettype wire

//--- common/axi_pkg.sv
`default_nettype none

package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;

    localparam logic [ID_W-1:0] FETCH_ID = '0;

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    localparam logic [2:0] SIZE_4B = 3'd2;
    localparam logic [2:0] SIZE_8B = 3'd3;

    typedef enum logic [1:0] {
        OKAY,
        EXOKAY,
        SLVERR,
        DECERR
    } resp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   id;
        resp_t             resp;
        logic              last;
    } axi_r_t;

endpackage

`default_nettype wire

//--- icache/icache_tags.sv
`default_nettype none

module icache_tags (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [fetch_pkg::INDEX_W-1:0] index,
    input  logic [fetch_pkg::TAG_W-1:0]   tag,
    output fetch_pkg::way_vec_t           hit_ways,
    output fetch_pkg::way_vec_t           set_valid,
    input  logic                          fill_en,
    input  logic [fetch_pkg::WAY_W-1:0]   fill_way,
    input  logic                          flush
);

    fetch_pkg::way_vec_t [fetch_pkg::NUM_SETS-1:0] valid;
    logic [fetch_pkg::TAG_W-1:0] tags [fetch_pkg::NUM_WAYS][fetch_pkg::NUM_SETS];

    assign set_valid = valid[index];

    // All ways compared in parallel
    always_comb begin
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            hit_ways[w] = valid[index][w] && (tags[w][index] == tag);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;  // fence.i
        end else if (fill_en) begin
            valid[index][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_way][index] <= tag;
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_plru.sv
`default_nettype none

module icache_plru (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [fetch_pkg::INDEX_W-1:0] index,
    input  logic                          lookup,
    input  fetch_pkg::way_vec_t           hit_ways,
    input  fetch_pkg::way_vec_t           set_valid,
    output logic [fetch_pkg::WAY_W-1:0]   victim_way
);

    logic [fetch_pkg::NUM_SETS-1:0][fetch_pkg::PLRU_W-1:0] tree;
    logic [fetch_pkg::PLRU_W-1:0] cur;
    logic [fetch_pkg::WAY_W-1:0]  hit_way;
    logic [fetch_pkg::WAY_W-1:0]  free_way;
    logic [fetch_pkg::WAY_W-1:0]  tree_way;
    logic                         any_free;

    assign cur      = tree[index];
    assign any_free = ~&set_valid;

    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int w = fetch_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_ways[w]) begin
                hit_way = w[fetch_pkg::WAY_W-1:0];
            end
            if (!set_valid[w]) begin
                free_way = w[fetch_pkg::WAY_W-1:0];  // Lowest one wins
            end
        end
    end

    // Root, then pair select, then way within pair
    always_comb begin
        tree_way[2] = cur[0];
        tree_way[1] = tree_way[2] ? cur[2] : cur[1];
        tree_way[0] = cur[3 + tree_way[2:1]];
    end

    assign victim_way = any_free ? free_way : tree_way;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tree <= '0;
        end else if (lookup && |hit_ways) begin
            tree[index][0]                 <= ~hit_way[2];  // Point away from hit
            tree[index][1 + hit_way[2]]    <= ~hit_way[1];
            tree[index][3 + hit_way[2:1]]  <= ~hit_way[0];
        end
    end

endmodule

`default_nettype wire

//--- icache/icache_data.sv
`default_nettype none

module icache_data (
    input  logic                          clk,
    input  logic [fetch_pkg::INDEX_W-1:0] index,
    output logic [fetch_pkg::LINE_W-1:0]  lines [fetch_pkg::NUM_WAYS],
    input  logic                          fill_en,
    input  logic [fetch_pkg::WAY_W-1:0]   fill_way,
    input  logic [fetch_pkg::LINE_W-1:0]  fill_line
);

    logic [fetch_pkg::LINE_W-1:0] mem [fetch_pkg::NUM_WAYS][fetch_pkg::NUM_SETS];

    // Whole set read at once
    always_comb begin
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            lines[w] = mem[w][index];
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            mem[fill_way][index] <= fill_line;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  fetch_pkg::fetch_req_t         req,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output fetch_pkg::fetch_resp_t        resp,
    output logic                          ar_valid,
    input  logic                          ar_ready,
    output axi_pkg::axi_ar_t              ar,
    input  logic                          r_valid,
    output logic                          r_ready,
    input  axi_pkg::axi_r_t               r,
    output logic [fetch_pkg::INDEX_W-1:0] index,
    output logic [fetch_pkg::TAG_W-1:0]   tag,
    input  fetch_pkg::way_vec_t           hit_ways,
    input  logic [fetch_pkg::LINE_W-1:0]  lines [fetch_pkg::NUM_WAYS],
    input  logic [fetch_pkg::WAY_W-1:0]   victim_way,
    output logic                          lookup,
    output logic                          fill_en,
    output logic [fetch_pkg::WAY_W-1:0]   fill_way,
    output logic [fetch_pkg::LINE_W-1:0]  fill_line,
    output logic                          flush
);

    typedef enum logic [2:0] {IDLE, LOOKUP, AR, R, FILL, RESP} state_t;

    state_t                       state;
    fetch_pkg::fetch_addr_t       pc_q;
    fetch_pkg::fetch_resp_t       resp_q;
    fetch_pkg::fetch_resp_t       lookup_resp;
    logic [fetch_pkg::LINE_W-1:0] line_q;
    logic [fetch_pkg::LINE_W-1:0] hit_line;
    logic                         cached;
    logic                         misalign;
    logic                         r_ok;

    function automatic logic [fetch_pkg::INSTR_W-1:0] pick_instr(
        input logic [fetch_pkg::LINE_W-1:0] line,
        input logic                         upper
    );
        return upper ? line[63:32] : line[31:0];
    endfunction

    assign index    = pc_q.fields.index;
    assign tag      = pc_q.fields.tag;
    assign cached   = pc_q.raw[fetch_pkg::UNCACHED_BIT];
    assign misalign = pc_q.fields.offset[1:0] != 2'b00;
    assign r_ok     = (r.resp == axi_pkg::OKAY) || (r.resp == axi_pkg::EXOKAY);

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (hit_ways[w]) begin
                hit_line = hit_line | lines[w];
            end
        end
    end

    always_comb begin
        lookup_resp.pc    = pc_q.raw;
        lookup_resp.instr = misalign ? '0 : pick_instr(hit_line, pc_q.fields.offset[2]);
        lookup_resp.trap  = misalign ? fetch_pkg::TRAP_MISALIGN : fetch_pkg::TRAP_NONE;
    end

    assign req_ready  = state == IDLE;
    assign flush      = req_ready && req_valid && req.fence;
    assign lookup     = (state == LOOKUP) && cached && !misalign;
    assign resp_valid = ((state == LOOKUP) && (misalign || (lookup && |hit_ways)))
                        || (state == RESP);
    assign resp       = (state == LOOKUP) ? lookup_resp : resp_q;
    assign ar_valid   = state == AR;
    assign r_ready    = state == R;
    assign fill_en    = state == FILL;
    assign fill_way   = victim_way;
    assign fill_line  = line_q;

    // Single beat, line aligned when cached
    always_comb begin
        ar.addr  = cached ? {pc_q.raw[31:fetch_pkg::OFFSET_W], {fetch_pkg::OFFSET_W{1'b0}}}
                          : pc_q.raw;
        ar.id    = axi_pkg::FETCH_ID;
        ar.len   = '0;
        ar.size  = cached ? axi_pkg::SIZE_8B : axi_pkg::SIZE_4B;
        ar.burst = axi_pkg::BURST_FIXED;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid && !req.fence) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (resp_valid) begin
                        state <= resp_ready ? IDLE : RESP;
                    end else begin
                        state <= AR;  // Miss or uncached
                    end
                end
                AR: begin
                    if (ar_ready) begin
                        state <= R;
                    end
                end
                R: begin
                    if (r_valid) begin
                        state <= (r_ok && cached) ? FILL : RESP;
                    end
                end
                FILL: begin
                    state <= RESP;
                end
                RESP: begin
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready && req_valid && !req.fence) begin
            pc_q.raw <= req.pc;
        end
        if (state == LOOKUP) begin
            resp_q <= lookup_resp;  // Held if stalled
        end
        if (r_ready && r_valid) begin
            line_q       <= r.data;
            resp_q.pc    <= pc_q.raw;
            resp_q.instr <= pick_instr(r.data, pc_q.fields.offset[2]);
            resp_q.trap  <= r_ok ? fetch_pkg::TRAP_NONE : fetch_pkg::TRAP_FETCH_FAULT;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`default_nettype none

module fetch_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  fetch_pkg::fetch_req_t  req,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output fetch_pkg::fetch_resp_t resp,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output axi_pkg::axi_ar_t       ar,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  axi_pkg::axi_r_t        r
);

    logic [fetch_pkg::INDEX_W-1:0] index;
    logic [fetch_pkg::TAG_W-1:0]   tag;
    fetch_pkg::way_vec_t           hit_ways;
    fetch_pkg::way_vec_t           set_valid;
    logic [fetch_pkg::LINE_W-1:0]  lines [fetch_pkg::NUM_WAYS];
    logic [fetch_pkg::WAY_W-1:0]   victim_way;
    logic                          lookup;
    logic                          fill_en;
    logic [fetch_pkg::WAY_W-1:0]   fill_way;
    logic [fetch_pkg::LINE_W-1:0]  fill_line;
    logic                          flush;

    fetch_ctrl i_fetch_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r          (r),
        .index      (index),
        .tag        (tag),
        .hit_ways   (hit_ways),
        .lines      (lines),
        .victim_way (victim_way),
        .lookup     (lookup),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_line  (fill_line),
        .flush      (flush)
    );

    icache_tags i_icache_tags (
        .clk       (clk),
        .rst       (rst),
        .index     (index),
        .tag       (tag),
        .hit_ways  (hit_ways),
        .set_valid (set_valid),
        .fill_en   (fill_en),
        .fill_way  (fill_way),
        .flush     (flush)
    );

    icache_plru i_icache_plru (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .lookup     (lookup),
        .hit_ways   (hit_ways),
        .set_valid  (set_valid),
        .victim_way (victim_way)
    );

    icache_data i_icache_data (
        .clk       (clk),
        .index     (index),
        .lines     (lines),
        .fill_en   (fill_en),
        .fill_way  (fill_way),
        .fill_line (fill_line)
    );

endmodule

`default_nettype wire

//--- tests/axi_mem_model.sv
`default_nettype none

module axi_mem_model (
    input  logic             clk,
    input  logic             rst,
    input  logic             ar_valid,
    output logic             ar_ready,
    input  axi_pkg::axi_ar_t ar,
    output logic             r_valid,
    input  logic             r_ready,
    output axi_pkg::axi_r_t  r
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {M_IDLE, M_ADDR, M_WAIT, M_DATA} mstate_t;

    mstate_t     state;
    int          stall;
    logic [31:0] addr_q;
    logic [31:0] line_addr;

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic in_error_window(input logic [31:0] addr);
        return (addr >= 32'hc000_0000) && (addr <= 32'hc000_00ff);
    endfunction

    assign line_addr = {addr_q[31:3], 3'b000};

    // Slave outputs move on the falling edge
    always @(negedge clk or posedge rst) begin
        if (rst) begin
            state    <= M_IDLE;
            stall    <= 0;
            addr_q   <= '0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r        <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (ar_valid) begin
                        stall <= $urandom_range(3, 0);
                        state <= M_ADDR;
                    end
                end
                M_ADDR: begin
                    if (stall == 0) begin
                        ar_ready <= 1'b1;
                        addr_q   <= ar.addr;
                        stall    <= $urandom_range(3, 0);
                        state    <= M_WAIT;
                    end else begin
                        stall <= stall - 1;
                    end
                end
                M_WAIT: begin
                    ar_ready <= 1'b0;  // Address taken on last rising edge
                    if (stall == 0) begin
                        r_valid <= 1'b1;
                        r.data  <= {mem_word(line_addr + 32'd4), mem_word(line_addr)};
                        r.id    <= axi_pkg::FETCH_ID;
                        r.resp  <= in_error_window(line_addr) ? axi_pkg::SLVERR : axi_pkg::OKAY;
                        r.last  <= 1'b1;
                        state   <= M_DATA;
                    end else begin
                        stall <= stall - 1;
                    end
                end
                default: begin
                    r_valid <= 1'b0;  // Beat taken on last rising edge
                    state   <= M_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_fetch_top.sv
`default_nettype none

module tb_fetch_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [31:0]      pc;
        logic             fence;
        fetch_pkg::trap_t trap;
        logic             bus;  // AXI read expected
    } stim_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   req_valid;
    logic                   req_ready;
    fetch_pkg::fetch_req_t  req;
    logic                   resp_valid;
    logic                   resp_ready;
    fetch_pkg::fetch_resp_t resp;
    logic                   ar_valid;
    logic                   ar_ready;
    axi_pkg::axi_ar_t       ar;
    logic                   r_valid;
    logic                   r_ready;
    axi_pkg::axi_r_t        r;

    string            row_name [$];
    stim_t            row_stim [$];
    int               bus_reads = 0;
    axi_pkg::axi_ar_t last_ar;
    int               value_errors = 0;
    int               protocol_errors = 0;
    int               timeouts = 0;

    logic                         ref_valid [fetch_pkg::NUM_SETS][fetch_pkg::NUM_WAYS];
    logic [fetch_pkg::TAG_W-1:0]  ref_tag   [fetch_pkg::NUM_SETS][fetch_pkg::NUM_WAYS];
    logic [fetch_pkg::PLRU_W-1:0] ref_tree  [fetch_pkg::NUM_SETS];

    always #4 clk = ~clk;

    fetch_top i_fetch_top (.*);

    axi_mem_model i_axi_mem_model (.*);

    always @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            bus_reads <= bus_reads + 1;
            last_ar   <= ar;
        end
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic in_error_window(input logic [31:0] addr);
        return (addr >= 32'hc000_0000) && (addr <= 32'hc000_00ff);
    endfunction

    function automatic void clear_valid();
        foreach (ref_valid[s, w]) begin
            ref_valid[s][w] = 1'b0;
        end
    endfunction

    function automatic int choose_victim(input int set);
        int half;
        int pair;
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (!ref_valid[set][w]) begin
                return w;
            end
        end
        half = int'(ref_tree[set][0]);
        pair = int'(ref_tree[set][1 + half]);
        return 4 * half + 2 * pair + int'(ref_tree[set][3 + 2 * half + pair]);
    endfunction

    function automatic void touch_tree(input int set, input int way);
        ref_tree[set][0]              = ~way[2];  // Point away from the used way
        ref_tree[set][1 + (way >> 2)] = ~way[1];
        ref_tree[set][3 + (way >> 1)] = ~way[0];
    endfunction

    function automatic logic predict_bus_read(input logic [31:0] pc);
        int                          set;
        int                          hit;
        int                          way;
        logic [fetch_pkg::TAG_W-1:0] pc_tag;
        set    = int'(pc[fetch_pkg::OFFSET_W +: fetch_pkg::INDEX_W]);
        pc_tag = pc[31 -: fetch_pkg::TAG_W];
        hit    = -1;
        if (pc[1:0] != 2'b00) begin
            return 1'b0;
        end
        if (!pc[31]) begin
            return 1'b1;  // Uncached space
        end
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == pc_tag) begin
                hit = w;
            end
        end
        if (hit >= 0) begin
            touch_tree(set, hit);
            return 1'b0;
        end
        if (!in_error_window(pc)) begin
            way                 = choose_victim(set);
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = pc_tag;
        end
        return 1'b1;
    endfunction

    task automatic add_row(input string name, input logic [31:0] pc, input logic fence,
                           input fetch_pkg::trap_t trap, input logic bus);
        row_name.push_back(name);
        row_stim.push_back(stim_t'{pc, fence, trap, bus});
    endtask

    task automatic build_table();
        add_row("miss_lo", 32'h8000_0100, 1'b0, fetch_pkg::TRAP_NONE, 1'b1);
        add_row("hit_lo", 32'h8000_0100, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("hit_hi", 32'h8000_0104, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("miss_hi", 32'h8000_020c, 1'b0, fetch_pkg::TRAP_NONE, 1'b1);
        add_row("hit_lo_2", 32'h8000_0208, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("uncached_hi", 32'h0000_1234, 1'b0, fetch_pkg::TRAP_NONE, 1'b1);
        add_row("uncached_again", 32'h0000_1234, 1'b0, fetch_pkg::TRAP_NONE, 1'b1);
        add_row("uncached_lo", 32'h0000_1238, 1'b0, fetch_pkg::TRAP_NONE, 1'b1);
        add_row("misalign_cached", 32'h8000_0102, 1'b0, fetch_pkg::TRAP_MISALIGN, 1'b0);
        add_row("misalign_uncached", 32'h0000_0401, 1'b0, fetch_pkg::TRAP_MISALIGN, 1'b0);
        add_row("fence", 32'h0000_0000, 1'b1, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("refetch_after_fence", 32'h8000_0100, 1'b0, fetch_pkg::TRAP_NONE, 1'b1);
        for (int k = 0; k < 8; k++) begin  // Set 5 filled way by way
            add_row($sformatf("fill_w%0d", k), 32'h8010_0028 + 32'(k << 9), 1'b0,
                    fetch_pkg::TRAP_NONE, 1'b1);
        end
        add_row("steer_w0", 32'h8010_0028, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("steer_w5", 32'h8010_0a28, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("steer_w2", 32'h8010_0428, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("evict_w6", 32'h8010_1028, 1'b0, fetch_pkg::TRAP_NONE, 1'b1);
        add_row("hit_w7", 32'h8010_0e28, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("hit_new_w6", 32'h8010_1028, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("hit_w1", 32'h8010_0228, 1'b0, fetch_pkg::TRAP_NONE, 1'b0);
        add_row("refetch_evicted", 32'h8010_0c28, 1'b0, fetch_pkg::TRAP_NONE, 1'b1);
        add_row("fault", 32'hc000_0010, 1'b0, fetch_pkg::TRAP_FETCH_FAULT, 1'b1);
        add_row("fault_again", 32'hc000_0010, 1'b0, fetch_pkg::TRAP_FETCH_FAULT, 1'b1);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("ERR %s %s: expected %h actual %h", name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_rule(input string name, input logic ok, input string what);
        assert (ok) else begin
            $display("%s: %s", name, what);
            protocol_errors++;
        end
    endtask

    task automatic run_row(input int i);
        string                  name;
        stim_t                  s;
        logic                   pred;
        int                     reads0;
        int                     cnt;
        logic                   done;
        logic                   seen;
        fetch_pkg::fetch_resp_t held;
        name   = row_name[i];
        s      = row_stim[i];
        reads0 = bus_reads;
        if (s.fence) begin
            clear_valid();
            pred = 1'b0;
        end else begin
            pred = predict_bus_read(s.pc);
        end
        check_value(name, "model bus read", 32'(s.bus), 32'(pred));
        req_valid = 1'b1;
        req.pc    = s.pc;
        req.fence = s.fence;
        cnt       = 0;
        while (!req_ready) begin
            if (cnt == TIMEOUT) begin
                $display("%s: the request was never accepted", name);
                timeouts++;
                return;
            end
            @(negedge clk);
            cnt++;
        end
        @(negedge clk);
        req_valid = 1'b0;  // Now in the lookup cycle
        if (s.fence) begin
            check_rule(name, !resp_valid, "a fence request produced a response");
        end else begin
            check_rule(name, resp_valid == !pred, "response timing in the lookup cycle is wrong");
            cnt  = 0;
            done = 1'b0;
            seen = 1'b0;
            while (!done) begin
                resp_ready = ($urandom_range(3, 0) != 0);
                if (resp_valid) begin
                    check_rule(name, !req_ready, "req_ready is high with a response pending");
                    check_rule(name, !seen || resp == held, "the response changed while stalled");
                    held = resp;
                    seen = 1'b1;
                    done = resp_ready;
                end
                if (!done) begin
                    if (cnt == TIMEOUT) begin
                        $display("%s: no response arrived", name);
                        timeouts++;
                        resp_ready = 1'b0;
                        return;
                    end
                    @(negedge clk);
                    cnt++;
                end
            end
            @(negedge clk);
            resp_ready = 1'b0;
            check_value(name, "pc", s.pc, held.pc);
            check_value(name, "trap", 32'(s.trap), 32'(held.trap));
            if (s.trap == fetch_pkg::TRAP_NONE) begin
                check_value(name, "instr", mem_word(s.pc), held.instr);
            end
        end
        check_value(name, "bus reads", 32'(pred), bus_reads - reads0);
        if (bus_reads != reads0) begin
            check_value(name, "ar size", 32'(s.pc[31] ? axi_pkg::SIZE_8B : axi_pkg::SIZE_4B),
                        32'(last_ar.size));
            check_value(name, "ar addr", s.pc[31] ? {s.pc[31:3], 3'b000} : s.pc, last_ar.addr);
            check_value(name, "ar len", 32'd0, 32'(last_ar.len));
            check_value(name, "ar burst", 32'(axi_pkg::BURST_FIXED), 32'(last_ar.burst));
            check_value(name, "ar id", 32'(axi_pkg::FETCH_ID), 32'(last_ar.id));
        end
    endtask

    initial begin
        void'($urandom(32'h91369d55));
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        clear_valid();
        foreach (ref_tree[s]) begin
            ref_tree[s] = '0;
        end
        build_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_rule("reset", req_ready && !resp_valid && !ar_valid && !r_ready,
                   "outputs after reset are wrong");
        for (int i = 0; i < row_name.size() && timeouts == 0; i++) begin
            run_row(i);
        end
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
common/fetch_pkg.sv
common/axi_pkg.sv
icache/icache_tags.sv
icache/icache_plru.sv
icache/icache_data.sv
design/fetch_ctrl.sv
design/fetch_top.sv
tests/axi_mem_model.sv
tests/tb_fetch_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_fetch_top -o tb_fetch_top

out=$(./obj_dir/tb_fetch_top)
echo "$out"

# Exit status follows the search for the pass line
echo "$out" | grep -qx 'Result: PASSED'
